// File: filelist.f
rtl/rv_exec_pkg.sv
rtl/register_file.sv
rtl/instruction_decoder.sv
rtl/alu.sv
rtl/rv_exec_core.sv
verification/rv_exec_core_tb.sv

// File: rtl/alu.sv
`default_nettype none

module alu (
  input  wire  [rv_exec_pkg::xlen-1:0] operand_a,
  input  wire  [rv_exec_pkg::xlen-1:0] operand_b,
  input  wire  [rv_exec_pkg::xlen-1:0] imm,
  input  wire                          use_imm,
  input  wire  rv_exec_pkg::alu_op_t   alu_op,
  output logic [rv_exec_pkg::xlen-1:0] result
);

  import rv_exec_pkg::*;

  logic [xlen-1:0] operand_b_sel;
  logic [4:0]      shamt;
  logic            lt_signed;
  logic            lt_unsigned;

  // I-type and LUI take the immediate as second operand
  assign operand_b_sel = use_imm ? imm : operand_b;

  assign shamt       = operand_b_sel[4:0];  // RV32 shifts use the low 5 bits only
  assign lt_signed   = $signed(operand_a) < $signed(operand_b_sel);
  assign lt_unsigned = operand_a < operand_b_sel;

  always_comb begin
    case (alu_op)
      alu_add:    result = operand_a + operand_b_sel;
      alu_sub:    result = operand_a - operand_b_sel;  // wraps modulo 2**xlen
      alu_and:    result = operand_a & operand_b_sel;
      alu_or:     result = operand_a | operand_b_sel;
      alu_xor:    result = operand_a ^ operand_b_sel;
      alu_sll:    result = operand_a << shamt;
      alu_srl:    result = operand_a >> shamt;
      alu_sra:    result = $signed(operand_a) >>> shamt;
      alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_pass_b: result = operand_b_sel;  // LUI, upper immediate already placed
      default:    result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/instruction_decoder.sv
`default_nettype none

module instruction_decoder #(
  parameter int reg_addr_bits = 5
) (
  input  wire                             instr_valid,
  input  wire  [31:0]                     instr,
  output logic [reg_addr_bits-1:0]        rs1,
  output logic [reg_addr_bits-1:0]        rs2,
  output logic [reg_addr_bits-1:0]        rd,
  output logic [rv_exec_pkg::xlen-1:0]    imm,
  output logic                            use_imm,
  output rv_exec_pkg::alu_op_t            alu_op,
  output logic                            write_enable,
  output logic                            result_valid,
  output logic                            illegal
);

  import rv_exec_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rd_field;
  logic [4:0] rs1_field;
  logic [4:0] rs2_field;
  logic       f7_zero;    // funct7 is all zero
  logic       f7_alt_ok;  // funct7 is zero or the alternate encoding
  logic       known;      // opcode and function fields are supported
  logic       uses_rs1;
  logic       uses_rs2;
  logic       fits;       // every used register index is below 2**reg_addr_bits
  logic       legal;

  // shared funct3 map for R-type and I-type, alt picks SUB and SRA
  function automatic alu_op_t base_op(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      funct3_add_sub: op = alt ? alu_sub : alu_add;
      funct3_sll:     op = alu_sll;
      funct3_slt:     op = alu_slt;
      funct3_sltu:    op = alu_sltu;
      funct3_xor:     op = alu_xor;
      funct3_srl_sra: op = alt ? alu_sra : alu_srl;
      funct3_or:      op = alu_or;
      funct3_and:     op = alu_and;
      default:        op = alu_add;
    endcase
    return op;
  endfunction

  assign opcode    = instr[6:0];
  assign rd_field  = instr[11:7];
  assign funct3    = instr[14:12];
  assign rs1_field = instr[19:15];
  assign rs2_field = instr[24:20];
  assign funct7    = instr[31:25];

  assign f7_zero   = (funct7 == 7'b0000000);
  assign f7_alt_ok = f7_zero || (funct7 == funct7_alt);

  assign rd  = rd_field[reg_addr_bits-1:0];
  assign rs1 = rs1_field[reg_addr_bits-1:0];
  assign rs2 = rs2_field[reg_addr_bits-1:0];

  always_comb begin
    known    = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    use_imm  = 1'b0;
    imm      = '0;
    alu_op   = alu_add;
    case (opcode)
      opcode_op: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        alu_op   = base_op(funct3, funct7 == funct7_alt);
        if ((funct3 == funct3_add_sub) || (funct3 == funct3_srl_sra)) begin
          known = f7_alt_ok;
        end else begin
          known = f7_zero;
        end
      end
      opcode_op_imm: begin
        uses_rs1 = 1'b1;
        use_imm  = 1'b1;
        imm      = {{(xlen-12){instr[31]}}, instr[31:20]};  // sign extend
        // no SUBI, only the right shift has an alternate form
        alu_op   = base_op(funct3, (funct3 == funct3_srl_sra) && (funct7 == funct7_alt));
        if (funct3 == funct3_sll) begin
          known = f7_zero;
        end else if (funct3 == funct3_srl_sra) begin
          known = f7_alt_ok;
        end else begin
          known = 1'b1;
        end
      end
      opcode_lui: begin
        use_imm = 1'b1;
        imm     = {instr[31:12], 12'b0};
        alu_op  = alu_pass_b;
        known   = 1'b1;
      end
      default: ;  // anything else is unsupported
    endcase

    // upper index bits must be clear, matters for RV32E
    fits = ((rd_field >> reg_addr_bits) == 5'd0) &&
           (!uses_rs1 || ((rs1_field >> reg_addr_bits) == 5'd0)) &&
           (!uses_rs2 || ((rs2_field >> reg_addr_bits) == 5'd0));

    legal        = known && fits;
    result_valid = instr_valid && legal;
    illegal      = instr_valid && !legal;
    write_enable = result_valid && (rd_field != 5'd0);  // x0 result is shown, not stored
  end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
`default_nettype none

module register_file #(
  parameter int size = 16,  // bits per word
  parameter int N    = 4    // address bits
) (
  input  wire             clock,
  input  wire             reset,
  input  wire             write_enable,
  input  wire  [N-1:0]    read_address1,
  input  wire  [N-1:0]    read_address2,
  input  wire  [N-1:0]    write_address,
  input  wire  [size-1:0] write_data,
  output logic [size-1:0] read_data1,
  output logic [size-1:0] read_data2
);

  // x0 is not stored, it is a constant zero on the read side
  logic [2**N-1:1][size-1:0] regs;
  logic [2**N-1:1]           write_sel;  // one-hot write enables

  // write address decoder
  for (genvar i = 1; i < 2**N; i++) begin : g_write_decode
    assign write_sel[i] = write_enable && (write_address == N'(i));
  end

  // register bank
  always_ff @(posedge clock) begin
    if (reset) begin
      regs <= '0;
    end else begin
      for (int i = 1; i < 2**N; i++) begin
        if (write_sel[i]) begin
          regs[i] <= write_data;
        end
      end
    end
  end

  // read muxes, index 0 returns ground
  always_comb begin
    if (read_address1 == '0) begin
      read_data1 = '0;
    end else begin
      read_data1 = regs[read_address1];
    end
  end

  always_comb begin
    if (read_address2 == '0) begin
      read_data2 = '0;
    end else begin
      read_data2 = regs[read_address2];
    end
  end

  // a write to a stored register lands in the addressed entry at the edge
  a_write_lands : assert property (@(posedge clock) disable iff (reset)
    (write_enable && (write_address != '0)) |=>
      (regs[$past(write_address)] == $past(write_data)))
    else $error("register_file: written data not found in the addressed register");

endmodule

`default_nettype wire

// File: rtl/rv_exec_core.sv
`default_nettype none

module rv_exec_core #(
  parameter int reg_addr_bits = 5  // 5 for RV32I, 4 for RV32E
) (
  input  wire                          clock,
  input  wire                          reset,
  input  wire                          instr_valid,
  input  wire  [31:0]                  instr,
  output logic                         result_valid,
  output logic [reg_addr_bits-1:0]     result_rd,
  output logic [rv_exec_pkg::xlen-1:0] result_data,
  output logic                         illegal
);

  import rv_exec_pkg::*;

  logic [reg_addr_bits-1:0] rs1;
  logic [reg_addr_bits-1:0] rs2;
  logic [xlen-1:0]          imm;
  logic                     use_imm;
  alu_op_t                  alu_op;
  logic                     write_enable;
  logic [xlen-1:0]          read_data1;
  logic [xlen-1:0]          read_data2;

  instruction_decoder #(
    .reg_addr_bits(reg_addr_bits)
  ) u_decoder (
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (result_rd),
    .imm         (imm),
    .use_imm     (use_imm),
    .alu_op      (alu_op),
    .write_enable(write_enable),
    .result_valid(result_valid),
    .illegal     (illegal)
  );

  register_file #(
    .size(xlen),
    .N   (reg_addr_bits)
  ) u_register_file (
    .clock        (clock),
    .reset        (reset),
    .write_enable (write_enable),
    .read_address1(rs1),
    .read_address2(rs2),
    .write_address(result_rd),
    .write_data   (result_data),  // ALU result goes back at the edge
    .read_data1   (read_data1),
    .read_data2   (read_data2)
  );

  alu u_alu (
    .operand_a(read_data1),
    .operand_b(read_data2),
    .imm      (imm),
    .use_imm  (use_imm),
    .alu_op   (alu_op),
    .result   (result_data)
  );

  // back to back dependent instructions see the committed value without forwarding
  a_write_visible_next : assert property (@(posedge clock) disable iff (reset)
    write_enable |=> (!instr_valid || (rs1 != $past(result_rd)) ||
                      (read_data1 == $past(result_data))))
    else $error("rv_exec_core: written value not visible to the next instruction");

endmodule

`default_nettype wire

// File: rtl/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

  localparam int xlen = 32;  // RV32 data word

  // major opcodes, instr[6:0]
  localparam logic [6:0] opcode_op     = 7'b0110011;  // register-register
  localparam logic [6:0] opcode_op_imm = 7'b0010011;  // register-immediate
  localparam logic [6:0] opcode_lui    = 7'b0110111;

  // funct3, instr[14:12]
  localparam logic [2:0] funct3_add_sub = 3'b000;
  localparam logic [2:0] funct3_sll     = 3'b001;
  localparam logic [2:0] funct3_slt     = 3'b010;
  localparam logic [2:0] funct3_sltu    = 3'b011;
  localparam logic [2:0] funct3_xor     = 3'b100;
  localparam logic [2:0] funct3_srl_sra = 3'b101;
  localparam logic [2:0] funct3_or      = 3'b110;
  localparam logic [2:0] funct3_and     = 3'b111;

  // funct7, instr[31:25]
  localparam logic [6:0] funct7_alt = 7'b0100000;  // SUB, SRA, SRAI

  // ALU operation select
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_and    = 4'd2,
    alu_or     = 4'd3,
    alu_xor    = 4'd4,
    alu_sll    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_slt    = 4'd8,
    alu_sltu   = 4'd9,
    alu_pass_b = 4'd10  // second operand straight through, used by LUI
  } alu_op_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rv_exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=rv_exec_core_tb
log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module "$top" -o "$top"
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
fi

if grep -qx "Simulation passed" "$log"; then
  echo "result: PASS"
  exit 0
fi

echo "result: FAIL, see $log"
exit 1

// File: verification/rv_exec_core_tb.sv
`default_nettype none

module rv_exec_core_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import rv_exec_pkg::*;

  localparam int reg_addr_bits = 5;
  localparam int num_random    = 2000;
  localparam int num_illegal   = 200;
  localparam int num_directed  = 120;  // upper bound over all directed and idle cycles
  localparam int timeout_ns    = (num_random + num_illegal + num_directed) * 40 + 4000;

  logic                     clock;
  logic                     reset;
  logic                     instr_valid;
  logic [31:0]              instr;
  logic                     result_valid;
  logic [reg_addr_bits-1:0] result_rd;
  logic [xlen-1:0]          result_data;
  logic                     illegal;

  logic [31:0]           lcg_state = 32'h238c4736;
  logic [31:0][xlen-1:0] shadow = '0;  // expected register contents
  string                 test_name = "reset";
  logic                  exp_valid;
  logic                  exp_illegal;
  logic [4:0]            exp_rd;
  logic [xlen-1:0]       exp_data;

  rv_exec_core #(
    .reg_addr_bits(reg_addr_bits)
  ) u_dut (
    .clock       (clock),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .result_valid(result_valid),
    .result_rd   (result_rd),
    .result_data (result_data),
    .illegal     (illegal)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    return (lcg_next() >> 8) % n;  // low bits of an LCG repeat quickly
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opcode_op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm12, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm12, rs1, f3, rd, opcode_op_imm};
  endfunction

  function automatic logic [31:0] lui(input logic [19:0] imm20, input logic [4:0] rd);
    return {imm20, rd, opcode_lui};
  endfunction

  // ISA semantics of one funct3 group, alt selects SUB or SRA
  function automatic logic [xlen-1:0] ref_alu(input logic [2:0] f3, input logic alt,
                                              input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b);
    logic [xlen-1:0] r;
    case (f3)
      funct3_add_sub: r = alt ? a - b : a + b;
      funct3_sll:     r = a << b[4:0];
      funct3_slt:     r = xlen'($signed(a) < $signed(b));
      funct3_sltu:    r = xlen'(a < b);
      funct3_xor:     r = a ^ b;
      funct3_or:      r = a | b;
      funct3_and:     r = a & b;
      default: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
    endcase
    return r;
  endfunction

  function automatic void predict(input logic [31:0] ins, input logic [31:0][xlen-1:0] regs,
                                  output logic valid, output logic [4:0] rd,
                                  output logic [xlen-1:0] data, output logic bad);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       shift_right;
    f3          = ins[14:12];
    f7          = ins[31:25];
    shift_right = (f3 == funct3_srl_sra);
    rd          = ins[11:7];
    data        = '0;
    bad         = 1'b0;
    case (ins[6:0])
      opcode_op: begin
        // only ADD/SUB and SRL/SRA have a second funct7 encoding
        bad  = !((f7 == 7'b0) || ((f7 == funct7_alt) && (f3 == funct3_add_sub || shift_right)));
        data = ref_alu(f3, f7 == funct7_alt, regs[ins[19:15]], regs[ins[24:20]]);
      end
      opcode_op_imm: begin
        if (f3 == funct3_sll) bad = (f7 != 7'b0);
        else if (shift_right) bad = !((f7 == 7'b0) || (f7 == funct7_alt));
        data = ref_alu(f3, shift_right && (f7 == funct7_alt), regs[ins[19:15]],
                       {{20{ins[31]}}, ins[31:20]});
      end
      opcode_lui: data = {ins[31:12], 12'b0};
      default:    bad = 1'b1;
    endcase
    valid = !bad;
  endfunction

  function automatic logic [31:0] random_legal();
    logic [2:0]  f3;
    logic [11:0] imm12;
    logic [31:0] ins;
    f3 = 3'(pick(8));
    case (pick(4))
      0, 1: ins = r_type((f3 == funct3_add_sub || f3 == funct3_srl_sra) && pick(2) == 1 ?
                         funct7_alt : 7'b0, 5'(pick(32)), 5'(pick(32)), f3, 5'(pick(32)));
      2: begin
        imm12 = 12'(pick(4096));
        if (f3 == funct3_sll || f3 == funct3_srl_sra) begin
          imm12[11:5] = (f3 == funct3_srl_sra && pick(2) == 1) ? funct7_alt : 7'b0;
          if (pick(3) == 0) imm12[4:0] = 5'd0;  // edge shift amounts
          else if (pick(2) == 0) imm12[4:0] = 5'd31;
        end
        ins = i_type(imm12, 5'(pick(32)), f3, 5'(pick(32)));
      end
      default: ins = lui(20'(pick(1 << 20)), 5'(pick(32)));
    endcase
    return ins;
  endfunction

  function automatic logic [31:0] random_illegal();
    logic [31:0] ins;
    ins = lcg_next();
    case (pick(3))
      0: begin
        ins[6:0] = 7'(pick(128));
        if (ins[6:0] == opcode_op || ins[6:0] == opcode_op_imm || ins[6:0] == opcode_lui)
          ins[6:0] = 7'b1111111;
      end
      1: begin
        ins[6:0]   = opcode_op;
        ins[31:25] = 7'(pick(128)) | 7'b0000001;  // bit 25 is never set in a legal R-type
      end
      default: begin
        ins[6:0]   = opcode_op_imm;
        ins[14:12] = (pick(2) == 1) ? funct3_sll : funct3_srl_sra;
        ins[31:25] = 7'(pick(128)) | 7'b0000001;
      end
    endcase
    return ins;
  endfunction

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string name, input logic [xlen-1:0] expected,
                            input logic [xlen-1:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_index(input string name, input logic [reg_addr_bits-1:0] expected,
                             input logic [reg_addr_bits-1:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %b, actual %b", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic issue(input string name, input logic [31:0] ins);
    @(posedge clock);
    #2;
    test_name   = name;
    instr_valid = 1'b1;
    instr       = ins;
  endtask

  task automatic idle(input string name, input int cycles);
    repeat (cycles) begin
      @(posedge clock);
      #2;
      test_name   = name;
      instr_valid = 1'b0;
      instr       = '0;
    end
  endtask

  // compare just before each edge, then commit to the shadow state
  initial begin
    forever begin
      @(posedge clock);
      #38;
      if (!reset) begin
        {exp_valid, exp_illegal, exp_rd, exp_data} = '0;
        if (instr_valid) predict(instr, shadow, exp_valid, exp_rd, exp_data, exp_illegal);
        check_flag({test_name, ": result_valid"}, exp_valid, result_valid);
        check_flag({test_name, ": illegal"}, exp_illegal, illegal);
        if (exp_valid) begin
          check_index({test_name, ": result_rd"}, exp_rd, result_rd);
          check_word({test_name, ": result_data"}, exp_data, result_data);
          if (exp_rd != 5'd0) shadow[exp_rd] = exp_data;
        end
      end
    end
  end

  initial begin
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    repeat (5) @(posedge clock);
    #2;
    reset = 1'b0;

    idle("idle after reset", 3);
    for (int i = 0; i < 32; i++)
      issue("add after reset", r_type(7'b0, 5'(31 - i), 5'(i), funct3_add_sub, 5'(i)));

    issue("lui x1", lui(20'h12345, 5'd1));
    issue("addi x1", i_type(12'h678, 5'd1, funct3_add_sub, 5'd1));
    issue("addi x2 minus one", i_type(12'hfff, 5'd0, funct3_add_sub, 5'd2));
    issue("add x3", r_type(7'b0, 5'd2, 5'd1, funct3_add_sub, 5'd3));
    issue("sub wrap x4", r_type(funct7_alt, 5'd1, 5'd0, funct3_add_sub, 5'd4));
    issue("sub x5", r_type(funct7_alt, 5'd2, 5'd0, funct3_add_sub, 5'd5));
    issue("sra x6", r_type(funct7_alt, 5'd5, 5'd2, funct3_srl_sra, 5'd6));
    issue("slt x7", r_type(7'b0, 5'd1, 5'd2, funct3_slt, 5'd7));
    issue("sltu x8", r_type(7'b0, 5'd1, 5'd2, funct3_sltu, 5'd8));
    issue("xor x9", r_type(7'b0, 5'd4, 5'd3, funct3_xor, 5'd9));
    issue("srli x10", i_type(12'd31, 5'd4, funct3_srl_sra, 5'd10));
    issue("slli x11", i_type(12'd31, 5'd5, funct3_sll, 5'd11));
    issue("srai x12", i_type({funct7_alt, 5'd31}, 5'd11, funct3_srl_sra, 5'd12));

    issue("addi to x0", i_type(12'h7ff, 5'd1, funct3_add_sub, 5'd0));
    issue("lui to x0", lui(20'hfffff, 5'd0));
    issue("read x0 after write", r_type(7'b0, 5'd0, 5'd0, funct3_add_sub, 5'd13));
    issue("or with x0", r_type(7'b0, 5'd1, 5'd0, funct3_or, 5'd14));

    for (int n = 0; n < num_random; n++) issue("random legal", random_legal());

    for (int n = 0; n < num_illegal; n++) issue("random illegal", random_illegal());
    for (int i = 1; i < 32; i++)
      issue("readback after illegal", r_type(7'b0, 5'd0, 5'(i), funct3_add_sub, 5'd0));

    idle("drain", 2);
    @(posedge clock);
    $display("Simulation passed");
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("timeout: the test sequence did not finish within %0d ns", timeout_ns);
    stop_with_failure();
  end

endmodule

`default_nettype wire
